/* Bender.yml */
package:
  name: mips_core

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/mips_isa_pkg.sv
      - rtl/pipe_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/register_file.sv
      - rtl/execute_stage.sv
      - rtl/writeback_stage.sv
      - rtl/mips_core.sv

  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_mips_core.sv

/* rtl/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and address width
`define CORE_XLEN 32

// Register file geometry
`define CORE_REG_AW 5
`define CORE_NUM_REGS 32

// First fetch after reset
`define CORE_RESET_PC 32'hBFC0_0000

`endif

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

`include "core_defines.svh"

module decode_stage
    import mips_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  if_id_t                  if_id_i,
    input  logic [`CORE_XLEN-1:0]   rs_data_i,
    input  logic [`CORE_XLEN-1:0]   rt_data_i,
    input  id_ex_t                  ex_fwd_i,
    input  logic [`CORE_XLEN-1:0]   ex_result_i,
    input  rf_write_t               wb_fwd_i,
    output logic [`CORE_REG_AW-1:0] rs_addr_o,
    output logic [`CORE_REG_AW-1:0] rt_addr_o,
    output id_ex_t                  id_ex_o
);

    instr_u                  instr;
    alu_op_e                 alu_op;
    logic                    known;
    logic                    i_form;
    logic                    sign_ext;
    logic                    is_shift;
    logic [`CORE_REG_AW-1:0] dest;
    logic [`CORE_XLEN-1:0]   rs_val;
    logic [`CORE_XLEN-1:0]   rt_val;
    logic [`CORE_XLEN-1:0]   imm_ext;
    id_ex_t                  id_ex_d;
    id_ex_t                  id_ex_q;

    // EX result first, then WB, then the array
    function automatic logic [`CORE_XLEN-1:0] fwd_operand(
        input logic [`CORE_REG_AW-1:0] addr,
        input logic [`CORE_XLEN-1:0]   rf_data
    );
        logic [`CORE_XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_fwd_i.valid && ex_fwd_i.wen && ex_fwd_i.dest == addr) begin
            value = ex_result_i;
        end else if (wb_fwd_i.en && wb_fwd_i.addr == addr) begin
            value = wb_fwd_i.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign instr     = if_id_i.instr;
    assign rs_addr_o = instr.r.rs;
    assign rt_addr_o = instr.r.rt;

    always_comb begin
        alu_op   = ALU_ADD;
        known    = 1'b1;
        i_form   = 1'b1;
        sign_ext = 1'b0;
        is_shift = 1'b0;
        case (instr.r.opcode)
            OP_SPECIAL: begin
                i_form = 1'b0;
                case (instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL: begin
                        alu_op   = ALU_SLL;
                        is_shift = 1'b1;
                    end
                    FN_SRL: begin
                        alu_op   = ALU_SRL;
                        is_shift = 1'b1;
                    end
                    FN_SRA: begin
                        alu_op   = ALU_SRA;
                        is_shift = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op   = ALU_ADD;
                sign_ext = 1'b1;
            end
            OP_SLTI: begin
                alu_op   = ALU_SLT;
                sign_ext = 1'b1;
            end
            OP_SLTIU: begin
                alu_op   = ALU_SLTU;
                sign_ext = 1'b1;
            end
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            OP_LUI:  alu_op = ALU_LUI;
            default: known = 1'b0;
        endcase
    end

    assign dest    = i_form ? instr.i.rt : instr.r.rd;
    assign rs_val  = fwd_operand(instr.r.rs, rs_data_i);
    assign rt_val  = fwd_operand(instr.r.rt, rt_data_i);
    assign imm_ext = sign_ext ? {{(`CORE_XLEN-16){instr.i.imm[15]}}, instr.i.imm}
                              : {{(`CORE_XLEN-16){1'b0}}, instr.i.imm};

    always_comb begin
        id_ex_d.valid  = if_id_i.valid;
        id_ex_d.pc     = if_id_i.pc;
        id_ex_d.alu_op = alu_op;
        id_ex_d.src_a  = is_shift ? {{(`CORE_XLEN-5){1'b0}}, instr.r.shamt} : rs_val;
        id_ex_d.src_b  = i_form ? imm_ext : rt_val;
        id_ex_d.dest   = dest;
        // Undefined words and r0 retire silently
        id_ex_d.wen    = if_id_i.valid && known && (dest != '0);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_q.valid <= 1'b0;
            id_ex_q.wen   <= 1'b0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

`include "core_defines.svh"

module execute_stage
    import mips_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  id_ex_t                id_ex_i,
    output logic [`CORE_XLEN-1:0] ex_result_o,
    output ex_wb_t                ex_wb_o
);

    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [4:0]            sa;
    logic [`CORE_XLEN-1:0] result;
    ex_wb_t                ex_wb_q;

    assign a  = id_ex_i.src_a;
    assign b  = id_ex_i.src_b;
    assign sa = a[4:0];

    // Shifts take the amount on A and the value on B
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, a < b};
            ALU_SLL:  result = b << sa;
            ALU_SRL:  result = b >> sa;
            ALU_SRA:  result = $unsigned($signed(b) >>> sa);
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    assign ex_result_o = result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_wb_q.valid <= 1'b0;
            ex_wb_q.wen   <= 1'b0;
        end else begin
            ex_wb_q.valid  <= id_ex_i.valid;
            ex_wb_q.wen    <= id_ex_i.wen;
            ex_wb_q.pc     <= id_ex_i.pc;
            ex_wb_q.dest   <= id_ex_i.dest;
            ex_wb_q.result <= result;
        end
    end

    assign ex_wb_o = ex_wb_q;

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps

`include "core_defines.svh"

module fetch_stage
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  instr_u                inst_data_i,
    input  logic                  inst_ok_i,
    output logic                  inst_en_o,
    output logic [`CORE_XLEN-1:0] inst_addr_o,
    output if_id_t                if_id_o
);

    logic [`CORE_XLEN-1:0] pc_q;
    if_id_t                if_id_d;
    if_id_t                if_id_q;

    // Fetch runs continuously once out of reset
    assign inst_en_o   = ~reset_i;
    assign inst_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (inst_ok_i) begin
            pc_q <= pc_q + `CORE_XLEN'd4;
        end
    end

    // Bubble while the port has not answered
    // Old payload kept
    always_comb begin
        if_id_d       = if_id_q;
        if_id_d.valid = inst_ok_i;
        if (inst_ok_i) begin
            if_id_d.pc    = pc_q;
            if_id_d.instr = inst_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            if_id_q.valid <= 1'b0;
        end else begin
            if_id_q <= if_id_d;
        end
    end

    assign if_id_o = if_id_q;

endmodule

/* rtl/mips_core.sv */
`timescale 1ns/1ps

`include "core_defines.svh"

module mips_core
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`CORE_XLEN-1:0]   inst_data_i,
    input  logic                    inst_ok_i,
    output logic                    inst_en_o,
    output logic [`CORE_XLEN-1:0]   inst_addr_o,
    output logic [`CORE_XLEN-1:0]   wb_pc_o,
    output logic [3:0]              wb_rf_wen_o,
    output logic [`CORE_REG_AW-1:0] wb_rf_wnum_o,
    output logic [`CORE_XLEN-1:0]   wb_rf_wdata_o
);

    if_id_t                  if_id;
    id_ex_t                  id_ex;
    ex_wb_t                  ex_wb;
    rf_write_t               rf_wr;
    logic [`CORE_REG_AW-1:0] rs_addr;
    logic [`CORE_REG_AW-1:0] rt_addr;
    logic [`CORE_XLEN-1:0]   rs_data;
    logic [`CORE_XLEN-1:0]   rt_data;
    logic [`CORE_XLEN-1:0]   ex_result;

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .inst_data_i (inst_data_i),
        .inst_ok_i   (inst_ok_i),
        .inst_en_o   (inst_en_o),
        .inst_addr_o (inst_addr_o),
        .if_id_o     (if_id)
    );

    // EX and WB results loop back for forwarding
    decode_stage decode_stage_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .if_id_i     (if_id),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .ex_fwd_i    (id_ex),
        .ex_result_i (ex_result),
        .wb_fwd_i    (rf_wr),
        .rs_addr_o   (rs_addr),
        .rt_addr_o   (rt_addr),
        .id_ex_o     (id_ex)
    );

    register_file register_file_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .wr_i      (rf_wr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    execute_stage execute_stage_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .id_ex_i     (id_ex),
        .ex_result_o (ex_result),
        .ex_wb_o     (ex_wb)
    );

    writeback_stage writeback_stage_inst (
        .ex_wb_i       (ex_wb),
        .rf_write_o    (rf_wr),
        .wb_pc_o       (wb_pc_o),
        .wb_rf_wen_o   (wb_rf_wen_o),
        .wb_rf_wnum_o  (wb_rf_wnum_o),
        .wb_rf_wdata_o (wb_rf_wdata_o)
    );

endmodule

/* rtl/mips_isa_pkg.sv */
`include "core_defines.svh"

package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`CORE_REG_AW-1:0] rs;
        logic [`CORE_REG_AW-1:0] rt;
        logic [`CORE_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`CORE_REG_AW-1:0] rs;
        logic [`CORE_REG_AW-1:0] rt;
        logic [15:0]             imm;
    } i_fields_t;

    // Same word seen as R-type or I-type
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

/* rtl/pipe_pkg.sv */
`include "core_defines.svh"

package pipe_pkg;

    import mips_isa_pkg::*;
    // Stage ports carry ISA types too
    export mips_isa_pkg::*;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        instr_u                instr;
    } if_id_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        alu_op_e                 alu_op;
        logic [`CORE_XLEN-1:0]   src_a;
        logic [`CORE_XLEN-1:0]   src_b;
        logic [`CORE_REG_AW-1:0] dest;
        logic                    wen;
    } id_ex_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        logic [`CORE_REG_AW-1:0] dest;
        logic                    wen;
        logic [`CORE_XLEN-1:0]   result;
    } ex_wb_t;

    // Register file write also used for WB forwarding
    typedef struct packed {
        logic                    en;
        logic [`CORE_REG_AW-1:0] addr;
        logic [`CORE_XLEN-1:0]   data;
    } rf_write_t;

endpackage

/* rtl/register_file.sv */
`timescale 1ns/1ps

`include "core_defines.svh"

module register_file
    import pipe_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [`CORE_REG_AW-1:0] rs_addr_i,
    input  logic [`CORE_REG_AW-1:0] rt_addr_i,
    input  rf_write_t               wr_i,
    output logic [`CORE_XLEN-1:0]   rs_data_o,
    output logic [`CORE_XLEN-1:0]   rt_data_o
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // r0 reads as zero
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

/* rtl/writeback_stage.sv */
`timescale 1ns/1ps

`include "core_defines.svh"

module writeback_stage
    import pipe_pkg::*;
(
    input  ex_wb_t                  ex_wb_i,
    output rf_write_t               rf_write_o,
    output logic [`CORE_XLEN-1:0]   wb_pc_o,
    output logic [3:0]              wb_rf_wen_o,
    output logic [`CORE_REG_AW-1:0] wb_rf_wnum_o,
    output logic [`CORE_XLEN-1:0]   wb_rf_wdata_o
);

    logic retire_wr;

    // Bubbles never write
    assign retire_wr = ex_wb_i.valid & ex_wb_i.wen;

    assign rf_write_o.en   = retire_wr;
    assign rf_write_o.addr = ex_wb_i.dest;
    assign rf_write_o.data = ex_wb_i.result;

    // Debug trace
    // Byte enables all follow the single write
    assign wb_pc_o       = ex_wb_i.pc;
    assign wb_rf_wen_o   = {4{retire_wr}};
    assign wb_rf_wnum_o  = ex_wb_i.dest;
    assign wb_rf_wdata_o = ex_wb_i.result;

endmodule

/* sim.f */
+incdir+rtl
+incdir+tb
rtl/mips_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/mips_core.sv
tb/tb_mips_core.sv

/* tb/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Columns: instruction word, expected destination, expected value
// Destination 0 marks a row that must not show up on the trace

localparam int NUM_ROWS = 31;

prog_row_t program_rows [NUM_ROWS];

task automatic load_program();
    // Operands and sign extension of ADDIU
    program_rows[0]  = '{i_word(OP_ADDIU, 5'd1, 5'd0, 16'h7FFF), 5'd1, 32'h0000_7FFF};
    program_rows[1]  = '{i_word(OP_ADDIU, 5'd2, 5'd0, 16'h8000), 5'd2, 32'hFFFF_8000};
    // EX and WB distance forwarding
    program_rows[2]  = '{r_word(FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0), 5'd3, 32'hFFFF_FFFF};
    program_rows[3]  = '{r_word(FN_SUBU, 5'd4, 5'd0, 5'd1, 5'd0), 5'd4, 32'hFFFF_8001};
    program_rows[4]  = '{i_word(OP_LUI, 5'd5, 5'd0, 16'h8000), 5'd5, 32'h8000_0000};
    // Wraps to zero
    program_rows[5]  = '{r_word(FN_ADDU, 5'd6, 5'd5, 5'd5, 5'd0), 5'd6, 32'h0000_0000};
    program_rows[6]  = '{r_word(FN_SUBU, 5'd7, 5'd2, 5'd1, 5'd0), 5'd7, 32'hFFFF_0001};
    program_rows[7]  = '{r_word(FN_AND, 5'd8, 5'd3, 5'd2, 5'd0), 5'd8, 32'hFFFF_8000};
    program_rows[8]  = '{r_word(FN_OR, 5'd9, 5'd1, 5'd5, 5'd0), 5'd9, 32'h8000_7FFF};
    program_rows[9]  = '{r_word(FN_XOR, 5'd10, 5'd9, 5'd3, 5'd0), 5'd10, 32'h7FFF_8000};
    program_rows[10] = '{r_word(FN_NOR, 5'd11, 5'd1, 5'd2, 5'd0), 5'd11, 32'h0000_0000};
    // Negative against positive in signed and unsigned compare
    program_rows[11] = '{r_word(FN_SLT, 5'd12, 5'd2, 5'd1, 5'd0), 5'd12, 32'h0000_0001};
    program_rows[12] = '{r_word(FN_SLTU, 5'd13, 5'd2, 5'd1, 5'd0), 5'd13, 32'h0000_0000};
    program_rows[13] = '{r_word(FN_SLL, 5'd14, 5'd0, 5'd1, 5'd4), 5'd14, 32'h0007_FFF0};
    program_rows[14] = '{r_word(FN_SRL, 5'd15, 5'd0, 5'd2, 5'd8), 5'd15, 32'h00FF_FF80};
    program_rows[15] = '{r_word(FN_SRA, 5'd16, 5'd0, 5'd2, 5'd8), 5'd16, 32'hFFFF_FF80};
    program_rows[16] = '{r_word(FN_SRA, 5'd17, 5'd0, 5'd5, 5'd31), 5'd17, 32'hFFFF_FFFF};
    // Immediate forms
    program_rows[17] = '{i_word(OP_SLTI, 5'd18, 5'd2, 16'hFFFF), 5'd18, 32'h0000_0001};
    program_rows[18] = '{i_word(OP_SLTIU, 5'd19, 5'd1, 16'h8000), 5'd19, 32'h0000_0001};
    program_rows[19] = '{i_word(OP_ANDI, 5'd20, 5'd2, 16'hF0F0), 5'd20, 32'h0000_8000};
    program_rows[20] = '{i_word(OP_ORI, 5'd21, 5'd0, 16'h8001), 5'd21, 32'h0000_8001};
    program_rows[21] = '{i_word(OP_XORI, 5'd22, 5'd3, 16'hFFFF), 5'd22, 32'hFFFF_0000};
    program_rows[22] = '{i_word(OP_LUI, 5'd23, 5'd0, 16'h1234), 5'd23, 32'h1234_0000};
    // Write to r0, undefined opcode, undefined funct
    program_rows[23] = '{i_word(OP_ADDIU, 5'd0, 5'd1, 16'h0005), 5'd0, 32'h0000_0000};
    program_rows[24] = '{i_word(6'h3F, 5'd24, 5'd1, 16'h1111), 5'd0, 32'h0000_0000};
    program_rows[25] = '{r_word(6'h3F, 5'd25, 5'd1, 5'd2, 5'd0), 5'd0, 32'h0000_0000};
    // r0 must still read as zero
    program_rows[26] = '{r_word(FN_OR, 5'd24, 5'd0, 5'd23, 5'd0), 5'd24, 32'h1234_0000};
    program_rows[27] = '{i_word(OP_ADDIU, 5'd25, 5'd0, 16'h0001), 5'd25, 32'h0000_0001};
    program_rows[28] = '{i_word(OP_ADDIU, 5'd26, 5'd25, 16'h0001), 5'd26, 32'h0000_0002};
    program_rows[29] = '{r_word(FN_ADDU, 5'd27, 5'd26, 5'd25, 5'd0), 5'd27, 32'h0000_0003};
    program_rows[30] = '{r_word(FN_SUBU, 5'd28, 5'd27, 5'd26, 5'd0), 5'd28, 32'h0000_0001};
endtask

`endif

/* tb/tb_mips_core.sv */
`timescale 1ns/1ps

`include "core_defines.svh"

module tb_mips_core
    import mips_isa_pkg::*;
();

    logic                    clk;
    logic                    reset_i;
    logic [`CORE_XLEN-1:0]   inst_data_i;
    logic                    inst_ok_i;
    logic                    inst_en_o;
    logic [`CORE_XLEN-1:0]   inst_addr_o;
    logic [`CORE_XLEN-1:0]   wb_pc_o;
    logic [3:0]              wb_rf_wen_o;
    logic [`CORE_REG_AW-1:0] wb_rf_wnum_o;
    logic [`CORE_XLEN-1:0]   wb_rf_wdata_o;

    // One program row
    // Dest 0 means nothing retires to the trace
    typedef struct packed {
        logic [`CORE_XLEN-1:0]   word;
        logic [`CORE_REG_AW-1:0] dest;
        logic [`CORE_XLEN-1:0]   value;
    } prog_row_t;

    logic [31:0] lfsr_state;

    function automatic logic [`CORE_XLEN-1:0] r_word(
        input logic [5:0]              funct,
        input logic [`CORE_REG_AW-1:0] rd,
        input logic [`CORE_REG_AW-1:0] rs,
        input logic [`CORE_REG_AW-1:0] rt,
        input logic [4:0]              shamt
    );
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [`CORE_XLEN-1:0] i_word(
        input logic [5:0]              opcode,
        input logic [`CORE_REG_AW-1:0] rt,
        input logic [`CORE_REG_AW-1:0] rs,
        input logic [15:0]             imm
    );
        return {opcode, rs, rt, imm};
    endfunction

`include "tb_program.svh"

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_take(input int count);
        logic [31:0] bits;
        logic        fb;
        int          k;
        bits = '0;
        for (k = 0; k < count; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [`CORE_XLEN-1:0] fetch_word(input logic [`CORE_XLEN-1:0] addr);
        logic [`CORE_XLEN-1:0] index;
        index = (addr - `CORE_RESET_PC) >> 2;
        if (index < NUM_ROWS) begin
            return program_rows[index].word;
        end
        return '0;
    endfunction

    function automatic int next_writer(input int from);
        int r;
        r = from;
        while (r < NUM_ROWS && program_rows[r].dest == '0) begin
            r++;
        end
        return r;
    endfunction

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(
        input string                 name,
        input logic [`CORE_XLEN-1:0] expected,
        input logic [`CORE_XLEN-1:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_reg_num(
        input string                   name,
        input logic [`CORE_REG_AW-1:0] expected,
        input logic [`CORE_REG_AW-1:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_wen(input string name, input logic [3:0] expected,
                             input logic [3:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            stop_on_error();
        end
    endtask

    mips_core mips_core_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_data_i   (inst_data_i),
        .inst_ok_i     (inst_ok_i),
        .inst_en_o     (inst_en_o),
        .inst_addr_o   (inst_addr_o),
        .wb_pc_o       (wb_pc_o),
        .wb_rf_wen_o   (wb_rf_wen_o),
        .wb_rf_wnum_o  (wb_rf_wnum_o),
        .wb_rf_wdata_o (wb_rf_wdata_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Reset, then the instruction memory answering after 0 to 3 wait cycles
    initial begin : drive_stimulus
        int unsigned wait_left;
        reset_i     = 1'b1;
        inst_ok_i   = 1'b0;
        inst_data_i = '0;
        lfsr_state  = 32'd88279;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        forever begin
            wait_left = lfsr_take(2);
            while (wait_left != 0) begin
                inst_ok_i = 1'b0;
                wait_left--;
                @(negedge clk);
            end
            inst_ok_i   = 1'b1;
            inst_data_i = fetch_word(inst_addr_o);
            @(negedge clk);
        end
    end

    initial begin : watchdog
        repeat (NUM_ROWS * 5 + 20) @(posedge clk);
        $display("Trace stalled: not every program row retired within the time limit");
        stop_on_error();
    end

    // Outputs sampled on the rising edge before the flops update
    initial begin : check_trace
        int cycle;
        int row;
        load_program();
        for (cycle = 1; cycle <= 4; cycle++) begin
            @(posedge clk);
            check_flag("inst_en during reset", 1'b0, inst_en_o);
            if (cycle > 1) begin
                check_wen("wen during reset", 4'h0, wb_rf_wen_o);
            end
        end

        @(posedge clk);
        check_flag("inst_en after reset", 1'b1, inst_en_o);
        check_word("first fetch address", `CORE_RESET_PC, inst_addr_o);
        check_wen("wen before first retire", 4'h0, wb_rf_wen_o);

        row = next_writer(0);
        while (row < NUM_ROWS) begin
            @(posedge clk);
            if (wb_rf_wen_o !== 4'h0) begin
                check_wen($sformatf("row %0d wen", row), 4'hF, wb_rf_wen_o);
                check_word($sformatf("row %0d pc", row),
                           `CORE_RESET_PC + 4 * row, wb_pc_o);
                check_reg_num($sformatf("row %0d dest", row),
                              program_rows[row].dest, wb_rf_wnum_o);
                check_word($sformatf("row %0d value", row),
                           program_rows[row].value, wb_rf_wdata_o);
                row = next_writer(row + 1);
            end
        end

        // NOPs past the end must stay silent
        repeat (8) begin
            @(posedge clk);
            check_wen("retire after program end", 4'h0, wb_rf_wen_o);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
